// ==== logic/issue_config_pkg.sv ====
// sizing constants for the cluster; RS_SIZE must be a power of two and XLEN even for the mult split
package issue_config_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////////////

    localparam int XLEN    = 32;  // operand and result width
    localparam int PRF_LEN = 6;   // physical register tag width

    ////////////////////////////////////////////////////////////////////////////
    // reservation station
    ////////////////////////////////////////////////////////////////////////////

    localparam int RS_SIZE = 8;
    localparam int RS_LEN  = $clog2(RS_SIZE);  // slot index width

    ////////////////////////////////////////////////////////////////////////////
    // functional units
    ////////////////////////////////////////////////////////////////////////////

    // one ready bit per unit, indexed by fu_type_e
    localparam int NUM_FU      = 2;
    localparam int MULT_STAGES = 3;  // issue to result latency of the multiplier

endpackage

// ==== logic/issue_types_pkg.sv ====
// shared packet formats; operand tag is only meaningful while ready is low, value once it is high
package issue_types_pkg;

    import issue_config_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////////////////////

    // target unit, also the index into the fu ready vector
    typedef enum logic {
        FU_ALU  = 1'b0,
        FU_MULT = 1'b1
    } fu_type_e;

    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_SLL  = 4'h5,
        OP_SRL  = 4'h6,
        OP_SLT  = 4'h7,   // signed compare
        OP_MUL  = 4'h8,   // low word of product
        OP_MULH = 4'h9    // signed high word
    } alu_func_e;

    ////////////////////////////////////////////////////////////////////////////
    // packets
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic               ready;
        logic [PRF_LEN-1:0] tag;
        logic [XLEN-1:0]    value;
    } operand_t;

    // renamed instruction from dispatch
    typedef struct packed {
        logic               valid;
        fu_type_e           fu_type;
        alu_func_e          alu_func;
        logic [PRF_LEN-1:0] dest_tag;
        operand_t           opa;
        operand_t           opb;
    } dispatch_packet_t;

    // operands resolved, unit already chosen
    typedef struct packed {
        logic               valid;
        alu_func_e          alu_func;
        logic [PRF_LEN-1:0] dest_tag;
        logic [XLEN-1:0]    opa_value;
        logic [XLEN-1:0]    opb_value;
    } issue_packet_t;

    typedef struct packed {
        logic               valid;     // held until taken
        logic [PRF_LEN-1:0] dest_tag;
        logic [XLEN-1:0]    value;
    } fu_result_t;

    // broadcast, single cycle pulse per result
    typedef struct packed {
        logic               valid;
        logic [PRF_LEN-1:0] dest_tag;
        logic [XLEN-1:0]    value;
    } cdb_packet_t;

endpackage

// ==== logic/reservation_station.sv ====
// lowest free slot allocation, lowest ready slot issue; fu_ready must promise acceptance a cycle ahead
`timescale 1ns/100ps

module reservation_station
    import issue_config_pkg::*, issue_types_pkg::*;
(
    input  logic              clock,
    input  logic              reset,
    input  logic              flush,
    input  dispatch_packet_t  dispatch,
    input  cdb_packet_t       cdb,
    input  logic [NUM_FU-1:0] fu_ready,
    output logic              rs_full,
    output issue_packet_t     issue,
    output fu_type_e          issue_fu
);

    dispatch_packet_t   entries [RS_SIZE];  // valid bit doubles as busy
    dispatch_packet_t   disp_entry;         // incoming packet after bypass
    logic [RS_LEN:0]    occupancy;
    logic [RS_LEN-1:0]  free_idx;
    logic [RS_LEN-1:0]  grant_idx;
    logic [RS_SIZE-1:0] eligible;
    logic               dispatch_fire;
    logic               issue_fire;

    // capture a broadcast value into a waiting operand
    function automatic operand_t wake(operand_t op, cdb_packet_t bus);
        operand_t woken;
        woken = op;
        if (!op.ready && bus.valid && (op.tag == bus.dest_tag)) begin
            woken.ready = 1'b1;
            woken.value = bus.value;
        end
        return woken;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // allocation
    ////////////////////////////////////////////////////////////////////////////

    assign rs_full       = (occupancy == (RS_LEN+1)'(RS_SIZE));
    assign dispatch_fire = dispatch.valid && !rs_full;

    // lowest free slot wins
    always_comb begin
        free_idx = '0;
        for (int i = RS_SIZE-1; i >= 0; i--) begin
            if (!entries[i].valid) begin
                free_idx = RS_LEN'(i);
            end
        end
    end

    // same cycle bypass so a tag broadcast during dispatch is not missed
    always_comb begin
        disp_entry     = dispatch;
        disp_entry.opa = wake(dispatch.opa, cdb);
        disp_entry.opb = wake(dispatch.opb, cdb);
    end

    ////////////////////////////////////////////////////////////////////////////
    // selection
    ////////////////////////////////////////////////////////////////////////////

    // only stored readiness counts, a fresh wakeup is selectable next cycle
    always_comb begin
        grant_idx = '0;
        for (int i = RS_SIZE-1; i >= 0; i--) begin
            eligible[i] = entries[i].valid
                          && entries[i].opa.ready
                          && entries[i].opb.ready
                          && fu_ready[entries[i].fu_type];
            if (eligible[i]) begin
                grant_idx = RS_LEN'(i);
            end
        end
    end

    assign issue_fire = |eligible;

    ////////////////////////////////////////////////////////////////////////////
    // state update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            occupancy   <= '0;
            issue.valid <= 1'b0;
            for (int i = 0; i < RS_SIZE; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            occupancy <= occupancy + (RS_LEN+1)'(dispatch_fire) - (RS_LEN+1)'(issue_fire);

            // tag match on every stored operand
            for (int i = 0; i < RS_SIZE; i++) begin
                entries[i].opa <= wake(entries[i].opa, cdb);
                entries[i].opb <= wake(entries[i].opb, cdb);
            end

            issue.valid <= issue_fire;
            if (issue_fire) begin
                issue.alu_func  <= entries[grant_idx].alu_func;
                issue.dest_tag  <= entries[grant_idx].dest_tag;
                issue.opa_value <= entries[grant_idx].opa.value;
                issue.opb_value <= entries[grant_idx].opb.value;
                issue_fu        <= entries[grant_idx].fu_type;
                entries[grant_idx].valid <= 1'b0;  // slot free next cycle
            end

            // free slot never equals the granted one, which is busy
            if (dispatch_fire) begin
                entries[free_idx] <= disp_entry;
            end
        end
    end

endmodule

// ==== logic/int_alu.sv ====
// single cycle ALU; start must only follow a cycle with ready high, shifts use opb[4:0]
`timescale 1ns/100ps

module int_alu
    import issue_config_pkg::*, issue_types_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          flush,
    input  issue_packet_t issue,
    input  logic          start,
    input  logic          taken,
    output logic          ready,
    output fu_result_t    result
);

    logic [XLEN-1:0] alu_value;

    always_comb begin
        case (issue.alu_func)
            OP_ADD:  alu_value = issue.opa_value + issue.opb_value;
            OP_SUB:  alu_value = issue.opa_value - issue.opb_value;
            OP_AND:  alu_value = issue.opa_value & issue.opb_value;
            OP_OR:   alu_value = issue.opa_value | issue.opb_value;
            OP_XOR:  alu_value = issue.opa_value ^ issue.opb_value;
            OP_SLL:  alu_value = issue.opa_value << issue.opb_value[4:0];
            OP_SRL:  alu_value = issue.opa_value >> issue.opb_value[4:0];
            OP_SLT:  alu_value = XLEN'($signed(issue.opa_value) < $signed(issue.opb_value));
            default: alu_value = '0;  // mult opcodes never routed here
        endcase
    end

    // a start in flight fills the register next cycle and may not be taken
    assign ready = !start && (!result.valid || taken);

    ////////////////////////////////////////////////////////////////////////////
    // output register, holds until the arbiter takes it
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            result.valid <= 1'b0;
        end else if (start) begin
            result.valid    <= 1'b1;
            result.dest_tag <= issue.dest_tag;
            result.value    <= alu_value;
        end else if (taken) begin
            result.valid <= 1'b0;
        end
    end

endmodule

// ==== logic/mult_pipe.sv ====
// three stage signed multiplier; the whole pipe freezes while its last stage waits for the CDB
`timescale 1ns/100ps

module mult_pipe
    import issue_config_pkg::*, issue_types_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          flush,
    input  issue_packet_t issue,
    input  logic          start,
    input  logic          taken,
    output logic          ready,
    output fu_result_t    result
);

    typedef struct packed {
        logic               valid;
        logic [PRF_LEN-1:0] dest_tag;
        alu_func_e          func;
    } stage_ctrl_t;

    stage_ctrl_t                   ctrl_q [MULT_STAGES];
    logic signed [XLEN+XLEN/2:0]   pp_lo_q;   // opa times unsigned low half of opb
    logic signed [XLEN+XLEN/2-1:0] pp_hi_q;   // opa times signed high half of opb
    logic signed [2*XLEN-1:0]      prod_q;
    logic [XLEN-1:0]               word_q;
    logic                          advance;

    assign advance = !ctrl_q[MULT_STAGES-1].valid || taken;
    assign ready   = advance;  // low while stalled

    ////////////////////////////////////////////////////////////////////////////
    // control pipe
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            for (int s = 0; s < MULT_STAGES; s++) begin
                ctrl_q[s].valid <= 1'b0;
            end
        end else if (advance) begin
            ctrl_q[0].valid    <= start;
            ctrl_q[0].dest_tag <= issue.dest_tag;
            ctrl_q[0].func     <= issue.alu_func;
            for (int s = 1; s < MULT_STAGES; s++) begin
                ctrl_q[s] <= ctrl_q[s-1];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // datapath: partial products, sum, word select
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (advance) begin
            pp_lo_q <= $signed(issue.opa_value)
                       * $signed({1'b0, issue.opb_value[XLEN/2-1:0]});
            pp_hi_q <= $signed(issue.opa_value) * $signed(issue.opb_value[XLEN-1:XLEN/2]);
            prod_q  <= pp_lo_q + (pp_hi_q <<< (XLEN/2));  // both sign extended to 64
            word_q  <= (ctrl_q[MULT_STAGES-2].func == OP_MULH) ? prod_q[2*XLEN-1:XLEN]
                                                                : prod_q[XLEN-1:0];
        end
    end

    assign result.valid    = ctrl_q[MULT_STAGES-1].valid;
    assign result.dest_tag = ctrl_q[MULT_STAGES-1].dest_tag;
    assign result.value    = word_q;

endmodule

// ==== logic/cdb_arbiter.sv ====
// one result per cycle onto the CDB, multiplier first; an untaken result must be held by its unit
`timescale 1ns/100ps

module cdb_arbiter
    import issue_types_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        flush,
    input  fu_result_t  mult_result,
    input  fu_result_t  alu_result,
    output logic        mult_taken,
    output logic        alu_taken,
    output cdb_packet_t cdb
);

    fu_result_t winner;

    ////////////////////////////////////////////////////////////////////////////
    // fixed priority
    ////////////////////////////////////////////////////////////////////////////

    // older work sits in the mult pipe
    always_comb begin
        mult_taken = mult_result.valid;
        alu_taken  = alu_result.valid && !mult_result.valid;
        winner     = mult_result.valid ? mult_result : alu_result;
    end

    ////////////////////////////////////////////////////////////////////////////
    // broadcast register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid    <= winner.valid;     // idle when neither unit has a result
            cdb.dest_tag <= winner.dest_tag;
            cdb.value    <= winner.value;
        end
    end

endmodule

// ==== logic/issue_cluster.sv ====
// issue cluster top; dispatch must hold while rs_full is high, cdb is both output and wakeup bus
`timescale 1ns/100ps

module issue_cluster
    import issue_config_pkg::*, issue_types_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  logic             flush,
    input  dispatch_packet_t dispatch,
    output logic             rs_full,
    output cdb_packet_t      cdb
);

    issue_packet_t     issue;
    fu_type_e          issue_fu;
    logic [NUM_FU-1:0] fu_ready;
    logic              alu_start;
    logic              mult_start;
    logic              alu_ready;
    logic              mult_ready;
    logic              alu_taken;
    logic              mult_taken;
    fu_result_t        alu_result;
    fu_result_t        mult_result;

    // route the registered issue to its unit
    assign alu_start  = issue.valid && (issue_fu == FU_ALU);
    assign mult_start = issue.valid && (issue_fu == FU_MULT);

    assign fu_ready[FU_ALU]  = alu_ready;
    assign fu_ready[FU_MULT] = mult_ready;

    ////////////////////////////////////////////////////////////////////////////
    // blocks
    ////////////////////////////////////////////////////////////////////////////

    reservation_station u_rs (
        .clock    (clock),
        .reset    (reset),
        .flush    (flush),
        .dispatch (dispatch),
        .cdb      (cdb),         // wakeup feedback
        .fu_ready (fu_ready),
        .rs_full  (rs_full),
        .issue    (issue),
        .issue_fu (issue_fu)
    );

    int_alu u_alu (
        .clock  (clock),
        .reset  (reset),
        .flush  (flush),
        .issue  (issue),
        .start  (alu_start),
        .taken  (alu_taken),
        .ready  (alu_ready),
        .result (alu_result)
    );

    mult_pipe u_mult (
        .clock  (clock),
        .reset  (reset),
        .flush  (flush),
        .issue  (issue),
        .start  (mult_start),
        .taken  (mult_taken),
        .ready  (mult_ready),
        .result (mult_result)
    );

    cdb_arbiter u_arb (
        .clock       (clock),
        .reset       (reset),
        .flush       (flush),
        .mult_result (mult_result),
        .alu_result  (alu_result),
        .mult_taken  (mult_taken),
        .alu_taken   (alu_taken),
        .cdb         (cdb)
    );

endmodule

// ==== tests/issue_cluster_checker.sv ====
// SVA bound into the reservation station; all rules but the reset one are off while reset is high
`timescale 1ns/100ps

module issue_cluster_checker
    import issue_config_pkg::*, issue_types_pkg::*;
(
    input logic              clock,
    input logic              reset,
    input logic              flush,
    input logic              rs_full,
    input logic [RS_LEN:0]   occupancy,
    input logic [NUM_FU-1:0] fu_ready,
    input issue_packet_t     issue,
    input fu_type_e          issue_fu
);

    int unsigned       error_count = 0;
    logic [NUM_FU-1:0] fu_ready_q;  // what the selector saw

    always_ff @(posedge clock) begin
        fu_ready_q <= fu_ready;
    end

    // a full RS may only shrink, any write would grow the count
    assert property (@(posedge clock) disable iff (reset)
                     rs_full |=> (occupancy <= $past(occupancy)))
        else begin
            $error("entry written while rs_full was high");
            error_count++;
        end

    assert property (@(posedge clock) disable iff (reset) occupancy <= RS_SIZE)
        else begin
            $error("occupancy %0d above RS_SIZE", occupancy);
            error_count++;
        end

    // issue only to a unit that promised to accept
    assert property (@(posedge clock) disable iff (reset) issue.valid |-> fu_ready_q[issue_fu])
        else begin
            $error("issue to unit %0d whose ready was low", issue_fu);
            error_count++;
        end

    assert property (@(posedge clock) (reset || flush) |=> !issue.valid)
        else begin
            $error("issue.valid high after reset or flush");
            error_count++;
        end

endmodule

bind reservation_station issue_cluster_checker u_checker (.*);

// ==== tests/tb_issue_cluster.sv ====
// random dependent traffic, an RS fill and a flush; each broadcast is checked against a tag model
`timescale 1ns/100ps

module tb_issue_cluster
    import issue_config_pkg::*, issue_types_pkg::*;
();

    logic               clock;
    logic               reset;
    logic               flush;
    dispatch_packet_t   dispatch;
    logic               rs_full;
    cdb_packet_t        cdb;
    dispatch_packet_t   pkt;                   // next packet held while rs_full
    logic               chain_mode;            // dependent mults to back up the RS
    logic [PRF_LEN-1:0] last_tag;
    logic [PRF_LEN-1:0] free_tags [$];
    logic               pending [2**PRF_LEN];  // dispatched but not yet broadcast
    alu_func_e          op_func [2**PRF_LEN];
    operand_t           op_a    [2**PRF_LEN];
    operand_t           op_b    [2**PRF_LEN];

    issue_cluster dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic stop_run(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] want);
        assert (got === want)
            else stop_run($sformatf("[FAIL] %0t %s = %h, expected %h", $time, name, got, want));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [XLEN-1:0] model_result(alu_func_e f, logic [XLEN-1:0] a,
                                                     logic [XLEN-1:0] b);
        logic signed [2*XLEN-1:0] prod;
        prod = $signed(a) * $signed(b);
        case (f)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
            OP_MUL:  return prod[XLEN-1:0];
            default: return prod[2*XLEN-1:XLEN];  // mulh
        endcase
    endfunction

    function automatic operand_t wake_operand(operand_t op, logic [PRF_LEN-1:0] tag,
                                              logic [XLEN-1:0] value);
        if (!op.ready && op.tag == tag) begin
            op.ready = 1'b1;
            op.value = value;
        end
        return op;
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int k = 0; k < 2**PRF_LEN; k++) n += pending[k];
        return n;
    endfunction

    // an operand still unknown keeps the instruction in the RS
    function automatic int waiting_count();
        int n;
        n = 0;
        for (int k = 0; k < 2**PRF_LEN; k++) begin
            if (pending[k] && !(op_a[k].ready && op_b[k].ready)) n++;
        end
        return n;
    endfunction

    task automatic clear_model();
        free_tags.delete();
        for (int k = 0; k < 2**PRF_LEN; k++) begin
            pending[k] = 1'b0;
            free_tags.push_back(PRF_LEN'(k));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    function automatic operand_t make_operand();
        operand_t           op;
        logic [PRF_LEN-1:0] waiting [$];
        for (int k = 0; k < 2**PRF_LEN; k++) begin
            if (pending[k]) waiting.push_back(PRF_LEN'(k));
        end
        op.ready = 1'b1;
        op.tag   = PRF_LEN'($urandom());
        case ($urandom_range(5))
            0:       op.value = '0;
            1:       op.value = 32'h8000_0000;
            2:       op.value = 32'hffff_ffff;
            3:       op.value = 32'h7fff_ffff;
            4:       op.value = XLEN'($urandom_range(40));  // shift amounts near the limit
            default: op.value = $urandom();
        endcase
        if (cdb.valid && pending[cdb.dest_tag] && $urandom_range(1) == 1) begin
            op.ready = 1'b0;  // hits the same cycle bypass
            op.tag   = cdb.dest_tag;
        end else if (waiting.size() > 0 && $urandom_range(2) == 0) begin
            op.ready = 1'b0;
            op.tag   = waiting[$urandom_range(waiting.size() - 1)];
        end
        return op;
    endfunction

    function automatic dispatch_packet_t make_packet();
        dispatch_packet_t p;
        p.valid    = 1'b1;
        p.alu_func = alu_func_e'(4'($urandom_range(9)));
        p.opa      = make_operand();
        p.opb      = make_operand();
        if (chain_mode) begin
            p.alu_func  = ($urandom_range(1) == 1) ? OP_MULH : OP_MUL;
            p.opb.ready = 1'b1;
            if (pending[last_tag]) begin
                p.opa.ready = 1'b0;
                p.opa.tag   = last_tag;
            end
        end
        p.fu_type  = (p.alu_func inside {OP_MUL, OP_MULH}) ? FU_MULT : FU_ALU;
        p.dest_tag = free_tags.pop_front();
        return p;
    endfunction

    // sampled mid cycle once outputs settle
    task automatic observe();
        logic [PRF_LEN-1:0] t;
        if (waiting_count() == RS_SIZE) begin
            check_value("rs_full", rs_full, 1'b1);
        end
        if (dispatch.valid && !rs_full) begin
            t          = dispatch.dest_tag;
            pending[t] = 1'b1;
            op_func[t] = dispatch.alu_func;
            op_a[t]    = dispatch.opa;
            op_b[t]    = dispatch.opb;
            last_tag   = t;
            pkt.valid  = 1'b0;
        end
        if (cdb.valid) begin
            t = cdb.dest_tag;
            assert (pending[t])
                else stop_run($sformatf("broadcast of tag %0d with no outstanding producer", t));
            assert (op_a[t].ready && op_b[t].ready)
                else stop_run($sformatf("tag %0d broadcast before its operands existed", t));
            check_value("cdb.value", cdb.value, model_result(op_func[t], op_a[t].value,
                                                             op_b[t].value));
            pending[t] = 1'b0;
            free_tags.push_back(t);
            for (int k = 0; k < 2**PRF_LEN; k++) begin
                op_a[k] = wake_operand(op_a[k], t, cdb.value);
                op_b[k] = wake_operand(op_b[k], t, cdb.value);
            end
            pkt.opa = wake_operand(pkt.opa, t, cdb.value);  // held packet not yet in the RS
            pkt.opb = wake_operand(pkt.opb, t, cdb.value);
        end
        check_value("u_checker.error_count", dut.u_rs.u_checker.error_count, '0);
    endtask

    task automatic step(input logic want);
        if (!pkt.valid && want && free_tags.size() > 0) pkt = make_packet();
        dispatch = pkt;
        @(negedge clock);
        observe();
        @(posedge clock);
        #1;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (pkt.valid || outstanding() > 0) begin
            if (n == 2000) stop_run("timeout waiting for outstanding tags to broadcast");
            else begin
                step(1'b0);
                n++;
            end
        end
    endtask

    task automatic wait_rs_full(input logic level);
        int n;
        n = 0;
        while (rs_full !== level) begin
            if (n == 2000) stop_run($sformatf("timeout waiting for rs_full to be %0b", level));
            else begin
                step(level);
                n++;
            end
        end
    endtask

    // every slot taken by an instruction that cannot have issued yet
    task automatic fill_rs();
        int n;
        n = 0;
        while (waiting_count() < RS_SIZE) begin
            if (n == 2000) stop_run("timeout waiting for the RS to fill with waiting entries");
            else begin
                step(1'b1);
                n++;
            end
        end
        check_value("rs_full", rs_full, 1'b1);
    endtask

    task automatic flush_cluster();
        flush     = 1'b1;
        pkt.valid = 1'b0;
        dispatch  = '0;
        @(negedge clock);
        observe();
        @(posedge clock);
        #1;
        flush = 1'b0;
        clear_model();  // all in flight work is gone
    endtask

    initial begin
        void'($urandom(32'hdcf6ac5b));
        reset      = 1'b1;
        flush      = 1'b0;
        dispatch   = '0;
        pkt        = '0;
        chain_mode = 1'b0;
        last_tag   = '0;
        clear_model();
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        check_value("cdb.valid", cdb.valid, '0);
        check_value("rs_full", rs_full, '0);
        repeat (400) step($urandom_range(3) != 0);
        drain();
        chain_mode = 1'b1;
        fill_rs();
        wait_rs_full(1'b0);
        chain_mode = 1'b0;
        drain();
        repeat (30) step(1'b1);
        flush_cluster();
        repeat (10) begin
            step(1'b0);
            check_value("cdb.valid", cdb.valid, '0);
            check_value("rs_full", rs_full, '0);
        end
        repeat (200) step($urandom_range(1) != 0);
        drain();
        check_value("u_checker.error_count", dut.u_rs.u_checker.error_count, '0);
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== issue_cluster.f ====
logic/issue_config_pkg.sv
logic/issue_types_pkg.sv
logic/reservation_station.sv
logic/int_alu.sv
logic/mult_pipe.sv
logic/cdb_arbiter.sv
logic/issue_cluster.sv
tests/issue_cluster_checker.sv
tests/tb_issue_cluster.sv

// ==== Bender.yml ====
package:
  name: issue_cluster

sources:
  - logic/issue_config_pkg.sv
  - logic/issue_types_pkg.sv
  - logic/reservation_station.sv
  - logic/int_alu.sv
  - logic/mult_pipe.sv
  - logic/cdb_arbiter.sv
  - logic/issue_cluster.sv
  - target: test
    files:
      - tests/issue_cluster_checker.sv
      - tests/tb_issue_cluster.sv
